//--- verilog/vid_pkg.sv
/*
 * Video timing package
 *   Display mode, beam position and register bus structs
 *   Register map indices
 *   Per-mode line, frame, sync and window timing constants
 */

package vid_pkg;

    // ========================================
    // Shared types
    // ========================================
    typedef struct packed {
        logic mono;           // Shift mode, monochrome
        logic ntsc;           // Low for PAL
    } video_mode_t;

    typedef struct packed {
        logic [6:0] hcnt;     // 2 MHz cycle in line
        logic [8:0] vcnt;     // Line in frame
        logic       line_end;
        logic       frame_start;
    } beam_pos_t;

    typedef struct packed {
        logic       sel;
        logic       we;
        logic [2:0] addr;
        logic [7:0] wdata;
    } reg_bus_t;

    // ========================================
    // Register map
    // ========================================
    localparam logic [2:0] REG_BASE_HI  = 3'd0;
    localparam logic [2:0] REG_BASE_MID = 3'd1;
    localparam logic [2:0] REG_BASE_LO  = 3'd2;
    localparam logic [2:0] REG_CNT_HI   = 3'd3;   // Live counter, read only
    localparam logic [2:0] REG_CNT_MID  = 3'd4;
    localparam logic [2:0] REG_CNT_LO   = 3'd5;
    localparam logic [2:0] REG_LINE_OFS = 3'd6;
    localparam logic [2:0] REG_SYNC     = 3'd7;   // Bit 1 ntsc, bit 2 mono

    // ========================================
    // Timing, in 2 MHz cycles and lines
    // ========================================
    localparam int LINE_LEN_PAL     = 128;
    localparam int LINE_LEN_NTSC    = 127;
    localparam int LINE_LEN_MONO    = 56;
    localparam int FRAME_LINES_PAL  = 313;
    localparam int FRAME_LINES_NTSC = 263;
    localparam int FRAME_LINES_MONO = 501;
    localparam int HSYNC_LEN        = 5;
    localparam int VSYNC_LINES      = 3;

    // Display enable windows, start inclusive, end exclusive
    localparam int H_DE_START_PAL  = 12;  localparam int H_DE_END_PAL  = 96;
    localparam int H_DE_START_NTSC = 11;  localparam int H_DE_END_NTSC = 95;
    localparam int H_DE_START_MONO = 2;   localparam int H_DE_END_MONO = 43;
    localparam int V_DE_START_PAL  = 62;  localparam int V_DE_END_PAL  = 262;
    localparam int V_DE_START_NTSC = 33;  localparam int V_DE_END_NTSC = 233;
    localparam int V_DE_START_MONO = 35;  localparam int V_DE_END_MONO = 435;

    // Blank windows, visible from end up to start
    localparam int H_BLANK_END_PAL  = 9;   localparam int H_BLANK_START_PAL  = 114;
    localparam int H_BLANK_END_NTSC = 8;   localparam int H_BLANK_START_NTSC = 114;
    localparam int V_BLANK_END_PAL  = 24;  localparam int V_BLANK_START_PAL  = 307;
    localparam int V_BLANK_END_NTSC = 15;  localparam int V_BLANK_START_NTSC = 257;

endpackage

//--- verilog/cycle_clock_gen.sv
/*
 * Beam step enable generator
 *   Free-running divider on clk32, one-cycle pulse every CYC_DIV clocks
 */

`timescale 1ns/1ns

module cycle_clock_gen #(
    parameter int CYC_DIV = 16
) (
    input  logic clk32,
    input  logic porb,
    output logic cyc_en_o
);

    localparam int CNT_W = $clog2(CYC_DIV);

    logic [CNT_W-1:0] div_cnt;
    logic             div_last;

    assign div_last = (div_cnt == CNT_W'(CYC_DIV - 1));

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            div_cnt <= '0;
        end else if (div_last) begin
            div_cnt <= '0;                   // Wrap
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign cyc_en_o = div_last;  // 2 MHz step

endmodule

//--- verilog/video_regs.sv
/*
 * Video register file
 *   Screen base (three bytes), line offset, sync and shift-mode bits
 *   Combinational read mux with live video counter readback
 */

`timescale 1ns/1ns

module video_regs
    import vid_pkg::*;
#(
    parameter int ADDR_W = 21
) (
    input  logic              clk32,
    input  logic              porb,
    input  reg_bus_t          bus_i,
    input  logic [ADDR_W-1:0] vid_addr_i,
    output logic [7:0]        reg_rdata_o,
    output video_mode_t       mode_o,
    output logic [ADDR_W-1:0] base_addr_o,
    output logic [7:0]        line_ofs_o
);

    // Upper byte carries the word-address bits above the low 15
    localparam int HI_W = ADDR_W - 15;

    logic [HI_W-1:0] base_hi;
    logic [7:0]      base_mid;
    logic [6:0]      base_lo;    // Byte bit 0 is not stored
    logic [7:0]      line_ofs;
    video_mode_t     mode_q;
    logic            wr_en;

    assign wr_en = bus_i.sel & bus_i.we;

    // ========================================
    // Register writes
    // ========================================
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            base_hi  <= '0;
            base_mid <= '0;
            base_lo  <= '0;
            line_ofs <= '0;
            mode_q   <= '0;                  // PAL colour
        end else if (wr_en) begin
            case (bus_i.addr)
                REG_BASE_HI:  base_hi  <= bus_i.wdata[HI_W-1:0];
                REG_BASE_MID: base_mid <= bus_i.wdata;
                REG_BASE_LO:  base_lo  <= bus_i.wdata[7:1];
                REG_LINE_OFS: line_ofs <= bus_i.wdata;
                REG_SYNC: begin
                    mode_q.ntsc <= bus_i.wdata[1];
                    mode_q.mono <= bus_i.wdata[2];
                end
                default: ;                   // Counter bytes ignore writes
            endcase
        end
    end

    // ========================================
    // Read mux
    // ========================================
    always_comb begin
        reg_rdata_o = 8'hFF;
        if (bus_i.sel && !bus_i.we) begin
            case (bus_i.addr)
                REG_BASE_HI:  reg_rdata_o = 8'(base_hi);
                REG_BASE_MID: reg_rdata_o = base_mid;
                REG_BASE_LO:  reg_rdata_o = {base_lo, 1'b0};
                REG_CNT_HI:   reg_rdata_o = 8'(vid_addr_i[ADDR_W-1:15]);
                REG_CNT_MID:  reg_rdata_o = vid_addr_i[14:7];
                REG_CNT_LO:   reg_rdata_o = {vid_addr_i[6:0], 1'b0};
                REG_LINE_OFS: reg_rdata_o = line_ofs;
                REG_SYNC:     reg_rdata_o = {5'b00000, mode_q.mono, mode_q.ntsc, 1'b0};
                default:      reg_rdata_o = 8'hFF;
            endcase
        end
    end

    assign mode_o      = mode_q;
    assign base_addr_o = {base_hi, base_mid, base_lo};
    assign line_ofs_o  = line_ofs;

    // Host side must never strobe a write without a select
    a_we_needs_sel: assert property (@(posedge clk32) disable iff (!porb)
        bus_i.we |-> bus_i.sel);

endmodule

//--- verilog/beam_counter.sv
/*
 * Beam position counter
 *   Per-mode line and frame length select
 *   Horizontal and vertical counters, line end and frame start flags
 *   Registered HSYNC and VSYNC
 */

`timescale 1ns/1ns

module beam_counter
    import vid_pkg::*;
(
    input  logic        clk32,
    input  logic        porb,
    input  logic        cyc_en_i,
    input  video_mode_t mode_i,
    output beam_pos_t   beam_o,
    output logic        hsync_n_o,
    output logic        vsync_n_o
);

    video_mode_t mode_q;         // Mode the counters run in
    logic [6:0]  hcnt;
    logic [8:0]  vcnt;
    logic [7:0]  line_len;       // 128 needs the extra bit
    logic [8:0]  frame_lines;
    logic        line_end;
    logic        frame_end;
    logic        mode_chg;

    always_comb begin
        if (mode_q.mono) begin
            line_len    = 8'(LINE_LEN_MONO);
            frame_lines = 9'(FRAME_LINES_MONO);
        end else if (mode_q.ntsc) begin
            line_len    = 8'(LINE_LEN_NTSC);
            frame_lines = 9'(FRAME_LINES_NTSC);
        end else begin
            line_len    = 8'(LINE_LEN_PAL);
            frame_lines = 9'(FRAME_LINES_PAL);
        end
    end

    assign line_end  = ({1'b0, hcnt} == line_len - 8'd1);
    assign frame_end = (vcnt == frame_lines - 9'd1);
    assign mode_chg  = (mode_i != mode_q);

    // ========================================
    // Position counters
    // ========================================
    // A mode switch restarts the frame so the position never exceeds the new lengths
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            mode_q <= '0;
            hcnt   <= '0;
            vcnt   <= '0;
        end else if (mode_chg) begin
            mode_q <= mode_i;
            hcnt   <= '0;
            vcnt   <= '0;
        end else if (cyc_en_i) begin
            if (line_end) begin
                hcnt <= '0;
                vcnt <= frame_end ? 9'd0 : vcnt + 9'd1;
            end else begin
                hcnt <= hcnt + 7'd1;
            end
        end
    end

    // Syncs follow the position one clk32 later
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hsync_n_o <= 1'b1;
            vsync_n_o <= 1'b1;
        end else begin
            hsync_n_o <= ({1'b0, hcnt} < line_len - 8'(HSYNC_LEN));  // Low at line tail
            vsync_n_o <= (vcnt >= 9'(VSYNC_LINES));                  // Low at frame top
        end
    end

    assign beam_o = '{hcnt: hcnt, vcnt: vcnt, line_end: line_end,
                      frame_start: (hcnt == 7'd0) && (vcnt == 9'd0)};

    a_hcnt_in_line: assert property (@(posedge clk32) disable iff (!porb)
        {1'b0, hcnt} < line_len);

endmodule

//--- verilog/display_enable_gen.sv
/*
 * Display enable and blanking generator
 *   Per-mode horizontal and vertical window bounds
 *   Registered DE and BLANK_N, mono never blanks
 */

`timescale 1ns/1ns

module display_enable_gen
    import vid_pkg::*;
(
    input  logic        clk32,
    input  logic        porb,
    input  video_mode_t mode_i,
    input  beam_pos_t   beam_i,
    output logic        de_o,
    output logic        blank_n_o
);

    logic [6:0] h_de_start, h_de_end, h_vis_start, h_vis_end;
    logic [8:0] v_de_start, v_de_end, v_vis_start, v_vis_end;
    logic       h_de, v_de, h_vis, v_vis;

    // Window bounds per mode
    always_comb begin
        h_vis_start = 7'(H_BLANK_END_PAL);
        h_vis_end   = 7'(H_BLANK_START_PAL);
        v_vis_start = 9'(V_BLANK_END_PAL);
        v_vis_end   = 9'(V_BLANK_START_PAL);
        if (mode_i.mono) begin
            h_de_start = 7'(H_DE_START_MONO);
            h_de_end   = 7'(H_DE_END_MONO);
            v_de_start = 9'(V_DE_START_MONO);
            v_de_end   = 9'(V_DE_END_MONO);
        end else if (mode_i.ntsc) begin
            h_de_start  = 7'(H_DE_START_NTSC);
            h_de_end    = 7'(H_DE_END_NTSC);
            v_de_start  = 9'(V_DE_START_NTSC);
            v_de_end    = 9'(V_DE_END_NTSC);
            h_vis_start = 7'(H_BLANK_END_NTSC);
            h_vis_end   = 7'(H_BLANK_START_NTSC);
            v_vis_start = 9'(V_BLANK_END_NTSC);
            v_vis_end   = 9'(V_BLANK_START_NTSC);
        end else begin
            h_de_start = 7'(H_DE_START_PAL);
            h_de_end   = 7'(H_DE_END_PAL);
            v_de_start = 9'(V_DE_START_PAL);
            v_de_end   = 9'(V_DE_END_PAL);
        end
    end

    assign h_de  = (beam_i.hcnt >= h_de_start)  && (beam_i.hcnt < h_de_end);
    assign v_de  = (beam_i.vcnt >= v_de_start)  && (beam_i.vcnt < v_de_end);
    assign h_vis = (beam_i.hcnt >= h_vis_start) && (beam_i.hcnt < h_vis_end);
    assign v_vis = (beam_i.vcnt >= v_vis_start) && (beam_i.vcnt < v_vis_end);

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            de_o      <= 1'b0;
            blank_n_o <= 1'b1;
        end else begin
            de_o      <= h_de & v_de;
            blank_n_o <= mode_i.mono | (h_vis & v_vis);  // Mono stays unblanked
        end
    end

endmodule

//--- verilog/video_addr_cnt.sv
/*
 * Video word-address counter
 *   Base reload at frame start, +1 per DE word
 *   Line offset added at the end of each line that showed data
 */

`timescale 1ns/1ns

module video_addr_cnt
    import vid_pkg::*;
#(
    parameter int ADDR_W = 21
) (
    input  logic              clk32,
    input  logic              porb,
    input  logic              cyc_en_i,
    input  beam_pos_t         beam_i,
    input  logic              de_i,
    input  logic [ADDR_W-1:0] base_addr_i,
    input  logic [7:0]        line_ofs_i,
    output logic [ADDR_W-1:0] vid_addr_o
);

    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] step;
    logic              line_had_de;   // DE seen on this line

    always_comb begin
        step = '0;
        if (de_i) begin
            step = ADDR_W'(1);
        end
        if (beam_i.line_end && (line_had_de || de_i)) begin
            step = step + ADDR_W'(line_ofs_i);
        end
    end

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            addr_q      <= '0;
            line_had_de <= 1'b0;
        end else if (cyc_en_i) begin
            if (beam_i.frame_start) begin
                addr_q      <= base_addr_i;  // New frame
                line_had_de <= 1'b0;
            end else begin
                addr_q      <= addr_q + step;
                line_had_de <= !beam_i.line_end && (line_had_de || de_i);
            end
        end
    end

    assign vid_addr_o = addr_q;

    // Outside DE and away from the line end the address holds
    a_no_inc_without_de: assert property (@(posedge clk32) disable iff (!porb)
        cyc_en_i && !de_i && !beam_i.line_end && !beam_i.frame_start
        |=> vid_addr_o == $past(vid_addr_o));

endmodule

//--- verilog/video_timing_top.sv
/*
 * Video timing top level
 *   Register port, 2 MHz enable, beam counter,
 *   DE/blank windows and video address counter
 */

`timescale 1ns/1ns

module video_timing_top
    import vid_pkg::*;
#(
    parameter int CYC_DIV = 16,   // clk32 cycles per beam step
    parameter int ADDR_W  = 21    // Word address width
) (
    input  logic              clk32,
    input  logic              porb,
    input  logic              reg_sel_i,
    input  logic              reg_we_i,
    input  logic [2:0]        reg_addr_i,
    input  logic [7:0]        reg_wdata_i,
    output logic [7:0]        reg_rdata_o,
    output logic              hsync_n_o,
    output logic              vsync_n_o,
    output logic              de_o,
    output logic              blank_n_o,
    output logic [ADDR_W-1:0] vid_addr_o
);

    reg_bus_t          reg_bus;
    video_mode_t       mode;
    beam_pos_t         beam;
    logic              cyc_en;
    logic [ADDR_W-1:0] base_addr;
    logic [7:0]        line_ofs;

    assign reg_bus = '{sel: reg_sel_i, we: reg_we_i, addr: reg_addr_i, wdata: reg_wdata_i};

    video_regs #(.ADDR_W(ADDR_W)) u_regs (
        .clk32(clk32), .porb(porb), .bus_i(reg_bus), .vid_addr_i(vid_addr_o),
        .reg_rdata_o(reg_rdata_o), .mode_o(mode), .base_addr_o(base_addr),
        .line_ofs_o(line_ofs)
    );

    cycle_clock_gen #(.CYC_DIV(CYC_DIV)) u_cyc (
        .clk32(clk32), .porb(porb), .cyc_en_o(cyc_en)
    );

    beam_counter u_beam (
        .clk32(clk32), .porb(porb), .cyc_en_i(cyc_en), .mode_i(mode),
        .beam_o(beam), .hsync_n_o(hsync_n_o), .vsync_n_o(vsync_n_o)
    );

    display_enable_gen u_de (
        .clk32(clk32), .porb(porb), .mode_i(mode), .beam_i(beam),
        .de_o(de_o), .blank_n_o(blank_n_o)
    );

    video_addr_cnt #(.ADDR_W(ADDR_W)) u_addr (
        .clk32(clk32), .porb(porb), .cyc_en_i(cyc_en), .beam_i(beam), .de_i(de_o),
        .base_addr_i(base_addr), .line_ofs_i(line_ofs), .vid_addr_o(vid_addr_o)
    );

endmodule

//--- verif/tb_video_timing.sv
/*
 * Testbench for the video timing top level
 *   Register write and readback, unselected read
 *   HSYNC, VSYNC, DE and blank monitors checked by assertions
 *   Frame end video address check in PAL, NTSC and mono
 */

`timescale 1ns/1ns

module tb_video_timing
    import vid_pkg::*;
();

    localparam int CYC_DIV    = 16;          // clk32 cycles per beam step
    localparam int ADDR_W     = 21;
    localparam int MAX_CYCLES = 3_000_000;   // Above three PAL frames of 641k cycles

    logic              clk32;
    logic              porb;
    logic              reg_sel, reg_we;
    logic [2:0]        reg_addr;
    logic [7:0]        reg_wdata, reg_rdata;
    logic              hsync_n, vsync_n, de, blank_n;
    logic [ADDR_W-1:0] vid_addr;

    int   cyc_count;
    int   exp_line, exp_frame, exp_hde, exp_vde;
    logic exp_mono;
    logic armed;                             // Monitors live for the current mode
    logic hs_q, vs_q, de_q;
    logic hs_valid, vs_valid, de_valid;
    int   hs_cnt, vs_cnt, de_cnt, de_lines;

    video_timing_top #(.CYC_DIV(CYC_DIV), .ADDR_W(ADDR_W)) dut (
        .clk32(clk32), .porb(porb), .reg_sel_i(reg_sel), .reg_we_i(reg_we),
        .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
        .hsync_n_o(hsync_n), .vsync_n_o(vsync_n), .de_o(de), .blank_n_o(blank_n),
        .vid_addr_o(vid_addr)
    );

    initial begin
        clk32 = 1'b0;
        forever #4 clk32 = ~clk32;
    end

    // ========================================
    // Error reporting
    // ========================================
    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input int exp, input int act);
        $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        abort_run();
    endtask

    task automatic report_error(input string what);
        $display("Error: %s", what);
        abort_run();
    endtask

    // ========================================
    // Timing monitors
    // ========================================
    // Each count restarts at the edge it measures from
    always @(posedge clk32) begin
        hs_q   <= hsync_n;
        vs_q   <= vsync_n;
        de_q   <= de;
        hs_cnt <= (hs_q && !hsync_n) ? 1 : hs_cnt + 1;
        vs_cnt <= (vs_q && !vsync_n) ? 1 : vs_cnt + 1;
        de_cnt <= (!de_q && de) ? 1 : de_cnt + 1;
        if (!armed) begin
            hs_valid <= 1'b0;
            vs_valid <= 1'b0;
            de_valid <= 1'b0;
            de_lines <= 0;
        end else begin
            if (hs_q && !hsync_n) hs_valid <= 1'b1;
            if (vs_q && !vsync_n) vs_valid <= 1'b1;
            if (!de_q && de) de_valid <= 1'b1;
            if (vs_q && !vsync_n) begin
                de_lines <= 0;               // New frame
            end else if (!de_q && de) begin
                de_lines <= de_lines + 1;
            end
        end
    end

    a_hs_period: assert property (@(posedge clk32) disable iff (!armed)
        $fell(hsync_n) && hs_valid |-> hs_cnt == exp_line * CYC_DIV)
        else report_mismatch("hsync period", exp_line * CYC_DIV, $sampled(hs_cnt));

    a_hs_width: assert property (@(posedge clk32) disable iff (!armed)
        $rose(hsync_n) && hs_valid |-> hs_cnt == HSYNC_LEN * CYC_DIV)
        else report_mismatch("hsync width", HSYNC_LEN * CYC_DIV, $sampled(hs_cnt));

    a_vs_period: assert property (@(posedge clk32) disable iff (!armed)
        $fell(vsync_n) && vs_valid |-> vs_cnt == exp_frame * exp_line * CYC_DIV)
        else report_mismatch("vsync period", exp_frame * exp_line * CYC_DIV,
                             $sampled(vs_cnt));

    a_vs_width: assert property (@(posedge clk32) disable iff (!armed)
        $rose(vsync_n) && vs_valid |-> vs_cnt == VSYNC_LINES * exp_line * CYC_DIV)
        else report_mismatch("vsync width", VSYNC_LINES * exp_line * CYC_DIV,
                             $sampled(vs_cnt));

    a_de_width: assert property (@(posedge clk32) disable iff (!armed)
        $fell(de) && de_valid |-> de_cnt == exp_hde * CYC_DIV)
        else report_mismatch("de width", exp_hde * CYC_DIV, $sampled(de_cnt));

    a_de_lines: assert property (@(posedge clk32) disable iff (!armed)
        $fell(vsync_n) && vs_valid |-> de_lines == exp_vde)
        else report_mismatch("de lines per frame", exp_vde, $sampled(de_lines));

    a_mono_blank: assert property (@(posedge clk32) disable iff (!armed)
        exp_mono |-> !$fell(blank_n))
        else report_error("blank_n_o fell while in monochrome mode");

    // ========================================
    // Register port access
    // ========================================
    task automatic reg_write(input logic [2:0] addr, input logic [7:0] data);
        @(negedge clk32);
        reg_sel   = 1'b1;
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk32);
        reg_sel = 1'b0;
        reg_we  = 1'b0;
    endtask

    task automatic reg_read(input logic [2:0] addr, output logic [7:0] data);
        @(negedge clk32);
        reg_sel  = 1'b1;
        reg_we   = 1'b0;
        reg_addr = addr;
        @(negedge clk32);
        data    = reg_rdata;
        reg_sel = 1'b0;
    endtask

    task automatic check_readback(input string name, input logic [2:0] addr,
                                  input logic [7:0] exp);
        logic [7:0] rd;
        reg_read(addr, rd);
        assert (rd == exp) else report_mismatch(name, exp, rd);
    endtask

    task automatic check_registers();
        logic [7:0] hi, mid, lo, ofs;
        hi  = 8'($urandom) & 8'h3F;          // Byte address bits 21:16
        mid = 8'($urandom);
        lo  = 8'($urandom);
        ofs = 8'($urandom);
        reg_write(REG_BASE_HI, hi);
        reg_write(REG_BASE_MID, mid);
        reg_write(REG_BASE_LO, lo);
        reg_write(REG_LINE_OFS, ofs);
        reg_write(REG_SYNC, 8'h04);          // Mono
        check_readback("base_hi readback", REG_BASE_HI, hi);
        check_readback("base_mid readback", REG_BASE_MID, mid);
        check_readback("base_lo readback", REG_BASE_LO, lo & 8'hFE);
        check_readback("line_ofs readback", REG_LINE_OFS, ofs);
        check_readback("sync readback", REG_SYNC, 8'h04);
        @(negedge clk32);
        reg_addr = REG_BASE_MID;             // Not selected
        @(negedge clk32);
        assert (reg_rdata == 8'hFF) else report_mismatch("unselected read", 8'hFF, reg_rdata);
    endtask

    // ========================================
    // Per-mode frame test
    // ========================================
    task automatic load_expect(input logic [7:0] sync_val);
        exp_mono = sync_val[2];
        if (sync_val[2]) begin
            exp_line  = LINE_LEN_MONO;
            exp_frame = FRAME_LINES_MONO;
            exp_hde   = H_DE_END_MONO - H_DE_START_MONO;
            exp_vde   = V_DE_END_MONO - V_DE_START_MONO;
        end else if (sync_val[1]) begin
            exp_line  = LINE_LEN_NTSC;
            exp_frame = FRAME_LINES_NTSC;
            exp_hde   = H_DE_END_NTSC - H_DE_START_NTSC;
            exp_vde   = V_DE_END_NTSC - V_DE_START_NTSC;
        end else begin
            exp_line  = LINE_LEN_PAL;
            exp_frame = FRAME_LINES_PAL;
            exp_hde   = H_DE_END_PAL - H_DE_START_PAL;
            exp_vde   = V_DE_END_PAL - V_DE_START_PAL;
        end
    endtask

    task automatic run_mode(input logic [7:0] sync_val);
        logic [7:0]        hi, mid, lo, ofs;
        logic [7:0]        rd_hi, rd_mid, rd_lo;
        logic [ADDR_W-1:0] exp_addr;
        logic [ADDR_W-1:0] act_addr;
        hi  = 8'($urandom) & 8'h3F;
        mid = 8'($urandom);
        lo  = 8'($urandom);
        ofs = 8'($urandom);
        @(posedge vsync_n);                  // Past the frame top
        @(negedge clk32);
        armed = 1'b0;
        reg_write(REG_BASE_HI, hi);
        reg_write(REG_BASE_MID, mid);
        reg_write(REG_BASE_LO, lo);
        reg_write(REG_LINE_OFS, ofs);
        // HSYNC rises one clk32 after the wrap step, so the next beam step
        // is 15 edges later and the mode switch restarts the frame right on it
        @(posedge hsync_n);
        repeat (13) @(posedge clk32);
        reg_write(REG_SYNC, sync_val);
        load_expect(sync_val);
        armed = 1'b1;
        @(negedge vsync_n);                  // Restarted frame
        @(negedge vsync_n);                  // One full frame later
        reg_read(REG_CNT_HI, rd_hi);
        reg_read(REG_CNT_MID, rd_mid);
        reg_read(REG_CNT_LO, rd_lo);
        exp_addr = {hi[5:0], mid, lo[7:1]} + ADDR_W'(exp_vde * (exp_hde + int'(ofs)));
        act_addr = {rd_hi[5:0], rd_mid, rd_lo[7:1]};
        assert (act_addr == exp_addr)
            else report_mismatch("frame end address", int'(exp_addr), int'(act_addr));
        // Output port holds the same word address until the next frame reload
        assert (vid_addr == exp_addr)
            else report_mismatch("vid_addr_o at frame end", int'(exp_addr), int'(vid_addr));
        check_readback("mode readback", REG_SYNC, sync_val);
    endtask

    // ========================================
    // Main sequence and timeout
    // ========================================
    initial begin
        int unsigned seed_val;
        seed_val  = $urandom(32'h27c3_199a);
        porb      = 1'b0;
        reg_sel   = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        armed     = 1'b0;
        exp_mono  = 1'b0;
        hs_q      = 1'b1;
        vs_q      = 1'b1;
        de_q      = 1'b0;
        repeat (5) @(posedge clk32);
        @(negedge clk32);
        porb = 1'b1;
        check_registers();
        run_mode(8'h02);                     // NTSC
        run_mode(8'h04);                     // Mono
        run_mode(8'h00);                     // PAL
        @(negedge clk32);
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        cyc_count = 0;
        while (cyc_count < MAX_CYCLES) begin
            @(posedge clk32);
            cyc_count = cyc_count + 1;
        end
        $display("Timeout after %0d clk32 cycles with frames still pending", cyc_count);
        abort_run();
    end

endmodule

//--- sim.f
verilog/vid_pkg.sv
verilog/cycle_clock_gen.sv
verilog/video_regs.sv
verilog/beam_counter.sv
verilog/display_enable_gen.sv
verilog/video_addr_cnt.sv
verilog/video_timing_top.sv
verif/tb_video_timing.sv

//--- Bender.yml
package:
  name: video_timing

sources:
  - verilog/vid_pkg.sv
  - verilog/cycle_clock_gen.sv
  - verilog/video_regs.sv
  - verilog/beam_counter.sv
  - verilog/display_enable_gen.sv
  - verilog/video_addr_cnt.sv
  - verilog/video_timing_top.sv
  - target: test
    files:
      - verif/tb_video_timing.sv
